//--- all.f
vec_pkg.sv
vec_regfile.sv
vec_alu.sv
vec_load_unit.sv
vec_wr_arbiter.sv
vec_unit_top.sv
vec_unit_assertions.sv
vec_unit_tb.sv

//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = vec_unit_tb
FILELIST   = all.f
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- vec_unit_tb.sv
// Directed testbench for the vector unit with clock, reset, watchdog, model and test tasks
`timescale 1ns/1ns

module vec_unit_tb;
	import vec_pkg::*;

	// ======================================================================
	// DUT and clock
	// ======================================================================

	// Cycles granted to the whole run: reset, then each test with room to spare
	localparam int watchdog_cycles = 16 + 64*8 + 32*8 + 4*10 + 64*8 + 8*20 + 500;
	// Longest wait for both producers to go idle
	localparam int idle_limit = 20;

	logic clk = 1'b0;
	logic reset;
	logic issue;
	vec_issue_t op_in;
	logic ld_strobe;
	vreg_wr_t ld_in;
	logic [VREG_AW-1:0] rd_addr;
	vec_word_t rd_data;
	logic alu_busy;
	logic ld_busy;

	// Shadow copy of the register file, updated as writes are issued
	vec_word_t shadow [VREG_COUNT];
	logic [31:0] rng_state = 32'h58914107;
	// Set when the load unit was the last producer to write
	logic ld_won_last = 1'b0;

	vec_unit_top u_vec_unit_top (
		.clk       (clk),
		.reset     (reset),
		.issue     (issue),
		.op_in     (op_in),
		.ld_strobe (ld_strobe),
		.ld_in     (ld_in),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.alu_busy  (alu_busy),
		.ld_busy   (ld_busy)
	);

	// Arbiter rules are watched inside the arbiter instance
	bind vec_wr_arbiter vec_unit_assertions u_vec_unit_assertions (
		.clk     (clk),
		.reset   (reset),
		.alu_req (alu_req),
		.ld_req  (ld_req),
		.alu_gnt (alu_gnt),
		.ld_gnt  (ld_gnt),
		.wr_en   (wr_en)
	);

	always #10 clk = ~clk;

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired, the run hung after %0d cycles", watchdog_cycles);
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog timeout");
	end

	// ======================================================================
	// Helpers and model
	// ======================================================================

	// Xorshift32 step on the shared generator state
	function automatic logic [31:0] xorshift_next();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic vec_word_t rand_word();
		return {xorshift_next(), xorshift_next(), xorshift_next(), xorshift_next()};
	endfunction

	function automatic vec_issue_t rand_issue();
		logic [31:0] x;
		vec_issue_t r;
		x = xorshift_next();
		r.op = alu_op_e'(x[1:0]);
		r.esize = x[2];
		r.vd = x[8:3];
		r.vs1 = x[14:9];
		r.vs2 = x[20:15];
		return r;
	endfunction

	// Selected bytes come from the new data, the rest stay as they were
	function automatic vec_word_t merge_bytes(input vec_word_t old, input vec_word_t data,
			input logic [VBYTES-1:0] sel);
		vec_word_t m;
		m = old;
		for (int b = 0; b < VBYTES; b++)
			if (sel[b])
				m[b*8 +: 8] = data[b*8 +: 8];
		return m;
	endfunction

	// Reference ALU, lanes are sized variables so results wrap per lane
	function automatic vec_word_t model_alu(input alu_op_e op, input logic esize,
			input vec_word_t a, input vec_word_t b);
		vec_word_u ua;
		vec_word_u ub;
		vec_word_u ur;
		ua = a;
		ub = b;
		ur = '0;
		if (esize) begin
			for (int i = 0; i < VWORDS; i++)
				case (op)
					op_add:  ur.words[i] = ua.words[i] + ub.words[i];
					op_sub:  ur.words[i] = ua.words[i] - ub.words[i];
					op_and:  ur.words[i] = ua.words[i] & ub.words[i];
					default: ur.words[i] = ua.words[i] ^ ub.words[i];
				endcase
		end else begin
			for (int i = 0; i < VBYTES; i++)
				case (op)
					op_add:  ur.bytes[i] = ua.bytes[i] + ub.bytes[i];
					op_sub:  ur.bytes[i] = ua.bytes[i] - ub.bytes[i];
					op_and:  ur.bytes[i] = ua.bytes[i] & ub.bytes[i];
					default: ur.bytes[i] = ua.bytes[i] ^ ub.bytes[i];
				endcase
		end
		return ur;
	endfunction

	task automatic check_value(input vec_word_t got, input vec_word_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Called just after a falling edge, so busy levels are stable
	task automatic wait_idle();
		int n;
		n = 0;
		while ((alu_busy || ld_busy) && n < idle_limit) begin
			@(negedge clk);
			n++;
		end
		if (alu_busy || ld_busy) begin
			$display("Producers still busy after %0d cycles, a write never finished", idle_limit);
			$display("Simulation finished: FAIL");
			$fatal(1, "busy timeout");
		end
	endtask

	task automatic read_expect(input logic [VREG_AW-1:0] addr, input vec_word_t exp);
		@(negedge clk);
		rd_addr = addr;
		#1;
		check_value(rd_data, exp, $sformatf("read of register %0d", addr));
	endtask

	task automatic read_check(input logic [VREG_AW-1:0] addr);
		read_expect(addr, shadow[addr]);
	endtask

	// ======================================================================
	// Test tasks
	// ======================================================================

	// One load, with an optional look at the bypassed value in the write cycle
	task automatic load_reg(input logic [VREG_AW-1:0] addr, input vec_word_t data,
			input logic [VBYTES-1:0] sel, input logic check_bypass);
		vec_word_t merged;
		merged = merge_bytes(shadow[addr], data, sel);
		@(negedge clk);
		ld_strobe = 1'b1;
		ld_in.addr = addr;
		ld_in.data = data;
		ld_in.sel = sel;
		rd_addr = addr;
		@(negedge clk);
		ld_strobe = 1'b0;
		check_value(128'(ld_busy), 128'd1, "ld_busy after strobe");
		if (check_bypass) begin
			#1;
			check_value(rd_data, merged, "bypassed read during load write");
		end
		shadow[addr] = merged;
		wait_idle();
		ld_won_last = 1'b1;
		read_check(addr);
	endtask

	task automatic run_op(input vec_issue_t op);
		vec_word_t expected;
		expected = model_alu(op.op, op.esize, shadow[op.vs1], shadow[op.vs2]);
		@(negedge clk);
		issue = 1'b1;
		op_in = op;
		@(negedge clk);
		issue = 1'b0;
		check_value(128'(alu_busy), 128'd1, "alu_busy after issue");
		shadow[op.vd] = expected;
		wait_idle();
		ld_won_last = 1'b0;
		read_check(op.vd);
	endtask

	// ALU issue and load strobe on the same edge, to different registers
	task automatic run_contention();
		vec_issue_t op;
		logic [31:0] x;
		logic [VREG_AW-1:0] ld_addr;
		vec_word_t ld_data;
		logic [VBYTES-1:0] ld_sel;
		vec_word_t alu_exp;
		vec_word_t ld_exp;
		logic alu_first;
		op = rand_issue();
		x = xorshift_next();
		// A nonzero XOR keeps the load off the ALU destination
		ld_addr = op.vd ^ {x[5:1], 1'b1};
		ld_sel = x[31:16];
		ld_data = rand_word();
		alu_exp = model_alu(op.op, op.esize, shadow[op.vs1], shadow[op.vs2]);
		ld_exp = merge_bytes(shadow[ld_addr], ld_data, ld_sel);
		// The producer that did not write last takes the contended port first
		alu_first = ld_won_last;
		@(negedge clk);
		issue = 1'b1;
		op_in = op;
		ld_strobe = 1'b1;
		ld_in.addr = ld_addr;
		ld_in.data = ld_data;
		ld_in.sel = ld_sel;
		@(negedge clk);
		issue = 1'b0;
		ld_strobe = 1'b0;
		check_value(128'({alu_busy, ld_busy}), 128'd3, "both busy after joint strobe");
		// One cycle later only the loser of the round is still waiting
		@(negedge clk);
		check_value(128'({alu_busy, ld_busy}), alu_first ? 128'd1 : 128'd2,
			"round-robin winner finished first");
		shadow[op.vd] = alu_exp;
		shadow[ld_addr] = ld_exp;
		wait_idle();
		ld_won_last = alu_first;
		read_check(op.vd);
		read_check(ld_addr);
	endtask

	// ======================================================================
	// Sequence
	// ======================================================================

	initial begin
		vec_issue_t op;
		logic [31:0] x;
		reset = 1'b1;
		issue = 1'b0;
		op_in = '0;
		ld_strobe = 1'b0;
		ld_in = '0;
		rd_addr = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value(128'({alu_busy, ld_busy}), 128'd0, "busy levels after reset");

		// Full-mask loads give every register a known value
		for (int r = 0; r < VREG_COUNT; r++)
			load_reg(r[VREG_AW-1:0], rand_word(), '1, 1'b0);

		// Partial masks, checked through the bypass and after the store
		for (int i = 0; i < 32; i++) begin
			x = xorshift_next();
			load_reg(x[5:0], rand_word(), x[31:16], 1'b1);
		end

		// 8'hFF plus 8'h01 wraps in byte lanes and carries in word lanes
		load_reg(6'd10, {VBYTES{8'hFF}}, '1, 1'b0);
		load_reg(6'd11, {VBYTES{8'h01}}, '1, 1'b0);
		op = '{op: op_add, esize: 1'b0, vd: 6'd12, vs1: 6'd10, vs2: 6'd11};
		run_op(op);
		read_expect(6'd12, '0);
		op = '{op: op_add, esize: 1'b1, vd: 6'd13, vs1: 6'd10, vs2: 6'd11};
		run_op(op);
		read_expect(6'd13, {VWORDS{32'h0101_0100}});

		for (int i = 0; i < 64; i++)
			run_op(rand_issue());

		// A plain load before every other round hands the contended port to the ALU
		for (int i = 0; i < 8; i++) begin
			if (i % 2 == 1) begin
				x = xorshift_next();
				load_reg(x[5:0], rand_word(), x[31:16], 1'b0);
			end
			run_contention();
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- vec_unit_assertions.sv
// Concurrent checks on the register write arbiter grants and write enable
`timescale 1ns/1ns

module vec_unit_assertions (
	input logic clk,
	input logic reset,
	input logic alu_req,
	input logic ld_req,
	input logic alu_gnt,
	input logic ld_gnt,
	input logic wr_en
);

	// ======================================================================
	// Arbiter rules
	// ======================================================================

	// Only one producer may own the write port in a cycle
	grants_one_hot: assert property (@(posedge clk) disable iff (reset)
		!(alu_gnt && ld_gnt))
		else $error("both write grants high");

	// A write never happens without somebody asking for it
	wr_en_needs_req: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> (alu_req || ld_req))
		else $error("wr_en without a request");

	// A lost round must be won in the next one
	alu_req_served: assert property (@(posedge clk) disable iff (reset)
		(alu_req && $past(alu_req)) |-> alu_gnt)
		else $error("ALU request held two cycles without a grant");

	ld_req_served: assert property (@(posedge clk) disable iff (reset)
		(ld_req && $past(ld_req)) |-> ld_gnt)
		else $error("load request held two cycles without a grant");

endmodule

//--- vec_unit_top.sv
// Vector register unit top with ALU, load unit, write arbiter and register file
`timescale 1ns/1ns

module vec_unit_top (
	input  logic                        clk,
	input  logic                        reset,
	// ALU issue
	input  logic                        issue,
	input  vec_pkg::vec_issue_t         op_in,
	// External load data
	input  logic                        ld_strobe,
	input  vec_pkg::vreg_wr_t           ld_in,
	// Inspection and store-data read port
	input  logic [vec_pkg::VREG_AW-1:0] rd_addr,
	output vec_pkg::vec_word_t          rd_data,
	// Producer status
	output logic                        alu_busy,
	output logic                        ld_busy
);
	import vec_pkg::*;

	// ======================================================================
	// Interconnect
	// ======================================================================

	logic [VREG_AW-1:0] rs1_addr;
	logic [VREG_AW-1:0] rs2_addr;
	vec_word_t rs1_data;
	vec_word_t rs2_data;
	logic alu_req;
	logic alu_gnt;
	logic ld_req;
	logic ld_gnt;
	vreg_wr_t alu_wr;
	vreg_wr_t ld_wr;
	logic wr_en;
	vreg_wr_t wr;

	vec_alu u_vec_alu (
		.clk      (clk),
		.reset    (reset),
		.issue    (issue),
		.op_in    (op_in),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.alu_req  (alu_req),
		.alu_gnt  (alu_gnt),
		.alu_wr   (alu_wr),
		.alu_busy (alu_busy)
	);

	vec_load_unit u_vec_load_unit (
		.clk       (clk),
		.reset     (reset),
		.ld_strobe (ld_strobe),
		.ld_in     (ld_in),
		.ld_req    (ld_req),
		.ld_gnt    (ld_gnt),
		.ld_wr     (ld_wr),
		.ld_busy   (ld_busy)
	);

	vec_wr_arbiter u_vec_wr_arbiter (
		.clk     (clk),
		.reset   (reset),
		.alu_req (alu_req),
		.ld_req  (ld_req),
		.alu_wr  (alu_wr),
		.ld_wr   (ld_wr),
		.alu_gnt (alu_gnt),
		.ld_gnt  (ld_gnt),
		.wr_en   (wr_en),
		.wr      (wr)
	);

	// Ports 0 and 1 serve the ALU sources, port 2 is the external read
	vec_regfile u_vec_regfile (
		.clk   (clk),
		.wr_en (wr_en),
		.wr    (wr),
		.ra0   (rs1_addr),
		.ra1   (rs2_addr),
		.ra2   (rd_addr),
		.rd0   (rs1_data),
		.rd1   (rs2_data),
		.rd2   (rd_data)
	);

endmodule

//--- vec_wr_arbiter.sv
// Round-robin arbiter between the ALU and the load unit for the register write port
`timescale 1ns/1ns

module vec_wr_arbiter (
	input  logic              clk,
	input  logic              reset,
	// Requests from the two producers
	input  logic              alu_req,
	input  logic              ld_req,
	input  vec_pkg::vreg_wr_t alu_wr,
	input  vec_pkg::vreg_wr_t ld_wr,
	// Grants back to the producers, one-hot or zero
	output logic              alu_gnt,
	output logic              ld_gnt,
	// Register-file write port
	output logic              wr_en,
	output vec_pkg::vreg_wr_t wr
);

	// Set when the load unit took the last grant, clear when the ALU did
	logic last_grant;

	// Grants are combinational so the write lands at the end of the
	// same cycle the request is seen
	always_comb begin
		alu_gnt = 1'b0;
		ld_gnt = 1'b0;
		if (alu_req && ld_req) begin
			// Both want the port, so the one that waited last time wins
			if (last_grant)
				alu_gnt = 1'b1;
			else
				ld_gnt = 1'b1;
		end else begin
			alu_gnt = alu_req;
			ld_gnt = ld_req;
		end
	end

	// Remember the winner only when a write actually happens
	always_ff @(posedge clk) begin
		if (reset)
			last_grant <= 1'b0;
		else if (wr_en)
			last_grant <= ld_gnt;
	end

	assign wr_en = alu_gnt | ld_gnt;
	assign wr = ld_gnt ? ld_wr : alu_wr;

endmodule

//--- vec_load_unit.sv
// One-entry load write buffer that holds external load data until the write port grants
`timescale 1ns/1ns

module vec_load_unit (
	input  logic              clk,
	input  logic              reset,
	// Load data from outside, taken on the strobe
	input  logic              ld_strobe,
	input  vec_pkg::vreg_wr_t ld_in,
	// Write-port request and grant
	output logic              ld_req,
	input  logic              ld_gnt,
	output vec_pkg::vreg_wr_t ld_wr,
	output logic              ld_busy
);

	// ======================================================================
	// Buffer control
	// ======================================================================

	logic full;

	// The buffer fills on a strobe while empty and empties at the edge
	// that ends the granted cycle
	// A strobe that arrives while full is dropped
	always_ff @(posedge clk) begin
		if (reset)
			full <= 1'b0;
		else if (full && ld_gnt)
			full <= 1'b0;
		else if (!full && ld_strobe)
			full <= 1'b1;
	end

	// ======================================================================
	// Buffer payload
	// ======================================================================

	// Address, data and byte mask are kept exactly as they arrived
	always_ff @(posedge clk) begin
		if (!full && ld_strobe)
			ld_wr <= ld_in;
	end

	// The request stays up as a level until the grant lands
	assign ld_req = full;
	assign ld_busy = full;

endmodule

//--- vec_alu.sv
// Element-wise vector ALU on byte or 32-bit lanes with a pending result register
`timescale 1ns/1ns

module vec_alu (
	input  logic                        clk,
	input  logic                        reset,
	// Issue strobe and the operation it carries
	input  logic                        issue,
	input  vec_pkg::vec_issue_t         op_in,
	// Source reads through register-file ports 0 and 1
	output logic [vec_pkg::VREG_AW-1:0] rs1_addr,
	output logic [vec_pkg::VREG_AW-1:0] rs2_addr,
	input  vec_pkg::vec_word_t          rs1_data,
	input  vec_pkg::vec_word_t          rs2_data,
	// Write-port request and grant
	output logic                        alu_req,
	input  logic                        alu_gnt,
	output vec_pkg::vreg_wr_t           alu_wr,
	output logic                        alu_busy
);
	import vec_pkg::*;

	// ======================================================================
	// Lane arithmetic
	// ======================================================================

	// One lane operation on 32 bits
	// Byte lanes use the low eight bits, which wrap the same way as an
	// 8-bit adder would, so no carry ever leaves a byte
	function automatic logic [31:0] lane_op(
		input alu_op_e op,
		input logic [31:0] x,
		input logic [31:0] y
	);
		logic [31:0] res;
		case (op)
			op_add:  res = x + y;
			op_sub:  res = x - y;
			op_and:  res = x & y;
			default: res = x ^ y;
		endcase
		return res;
	endfunction

	// Sources come straight from the issue so the read happens in the
	// cycle that ends with the issue edge
	assign rs1_addr = op_in.vs1;
	assign rs2_addr = op_in.vs2;

	vec_word_u src_a;
	vec_word_u src_b;
	vec_word_u result;
	logic [31:0] lane_res;

	always_comb begin
		src_a = rs1_data;
		src_b = rs2_data;
		result = '0;
		lane_res = '0;
		if (op_in.esize) begin
			// Four 32-bit lanes, carries run across the bytes of a word
			for (int w = 0; w < VWORDS; w++)
				result.words[w] = lane_op(op_in.op, src_a.words[w], src_b.words[w]);
		end else begin
			// Sixteen byte lanes, each one zero-extended into the lane op
			for (int b = 0; b < VBYTES; b++) begin
				lane_res = lane_op(op_in.op, {24'd0, src_a.bytes[b]}, {24'd0, src_b.bytes[b]});
				result.bytes[b] = lane_res[7:0];
			end
		end
	end

	// ======================================================================
	// Pending result
	// ======================================================================

	logic pending;

	// Set on an accepted issue and cleared at the edge that ends the
	// granted cycle, when the register file stores the result
	always_ff @(posedge clk) begin
		if (reset)
			pending <= 1'b0;
		else if (pending && alu_gnt)
			pending <= 1'b0;
		else if (!pending && issue)
			pending <= 1'b1;
	end

	// An ALU result always covers the whole register
	always_ff @(posedge clk) begin
		if (!pending && issue) begin
			alu_wr.addr <= op_in.vd;
			alu_wr.data <= result;
			alu_wr.sel <= '1;
		end
	end

	assign alu_req = pending;
	assign alu_busy = pending;

endmodule

//--- vec_regfile.sv
// Byte-maskable 64-entry vector register file with three bypassed read ports
`timescale 1ns/1ns

module vec_regfile (
	input  logic                       clk,
	// Write port, driven by the write arbiter
	input  logic                       wr_en,
	input  vec_pkg::vreg_wr_t          wr,
	// Read addresses, ports 0 and 1 feed the ALU and port 2 is external
	input  logic [vec_pkg::VREG_AW-1:0] ra0,
	input  logic [vec_pkg::VREG_AW-1:0] ra1,
	input  logic [vec_pkg::VREG_AW-1:0] ra2,
	output vec_pkg::vec_word_t          rd0,
	output vec_pkg::vec_word_t          rd1,
	output vec_pkg::vec_word_t          rd2
);
	import vec_pkg::*;

	// ======================================================================
	// Storage
	// ======================================================================

	// Small and read three ways at once, so it maps to LUT RAM
	(* ram_style = "distributed" *)
	vec_word_t regs [VREG_COUNT];

	// Each byte lane is written on its own so that masked bytes keep
	// their old contents
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < VBYTES; b++) begin
				if (wr.sel[b])
					regs[wr.addr][b*8 +: 8] <= wr.data[b*8 +: 8];
			end
		end
	end

	// ======================================================================
	// Read with write bypass
	// ======================================================================

	// Merges the write in flight into one read port, byte by byte
	// A byte is taken from the write data only when the port addresses
	// the register being written and that byte is selected
	function automatic vec_word_t bypass_read(
		input logic [VREG_AW-1:0] ra,
		input vec_word_t stored,
		input logic we,
		input vreg_wr_t w
	);
		vec_word_t merged;
		merged = stored;
		if (we && (w.addr == ra)) begin
			for (int b = 0; b < VBYTES; b++) begin
				if (w.sel[b])
					merged[b*8 +: 8] = w.data[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	// All three ports use the same merge so the ALU sources and the
	// store-data port agree during a write cycle
	assign rd0 = bypass_read(ra0, regs[ra0], wr_en, wr);
	assign rd1 = bypass_read(ra1, regs[ra1], wr_en, wr);
	assign rd2 = bypass_read(ra2, regs[ra2], wr_en, wr);

endmodule

//--- vec_pkg.sv
// Vector unit sizes, ALU opcodes, issue and write-request structs, lane view union
package vec_pkg;

	// ======================================================================
	// Sizes
	// ======================================================================

	// Width of one vector register in bits
	localparam int VLEN = 128;
	// Byte lanes per vector, also the width of a write byte mask
	localparam int VBYTES = VLEN / 8;
	// 32-bit lanes per vector
	localparam int VWORDS = VLEN / 32;
	// Number of architectural vector registers
	localparam int VREG_COUNT = 64;
	// Register address width
	localparam int VREG_AW = $clog2(VREG_COUNT);

	// ======================================================================
	// Data types
	// ======================================================================

	// One full vector register
	typedef logic [VLEN-1:0] vec_word_t;

	// The same vector seen either as sixteen byte lanes or as four
	// 32-bit lanes, the ALU picks the view from the element size
	typedef union packed {
		logic [VBYTES-1:0][7:0] bytes;
		logic [VWORDS-1:0][31:0] words;
	} vec_word_u;

	// Element-wise ALU operations
	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_sub = 2'd1,
		op_and = 2'd2,
		op_xor = 2'd3
	} alu_op_e;

	// One ALU issue
	// esize selects the lane width (0 gives byte lanes, 1 gives word lanes)
	typedef struct packed {
		alu_op_e op;
		logic esize;
		logic [VREG_AW-1:0] vd;
		logic [VREG_AW-1:0] vs1;
		logic [VREG_AW-1:0] vs2;
	} vec_issue_t;

	// A request on the single register-file write port
	// Only bytes whose sel bit is set are written
	typedef struct packed {
		logic [VREG_AW-1:0] addr;
		vec_word_t data;
		logic [VBYTES-1:0] sel;
	} vreg_wr_t;

endpackage
